//--- vlog.f
+incdir+.
pkt_gen_pkg.sv
pkt_req_if.sv
pkt_lfsr.sv
pkt_sched.sv
pkt_framer.sv
pkt_gen_top.sv
tb_pkt_gen.sv

//--- run.sh
#!/bin/sh
# build and run the packet generator testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_pkt_gen -f vlog.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_pkt_gen)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^PASS: all tests$"; then
	exit 0
fi
exit 1

//--- tb_pkt_gen.sv
// packet generator testbench
`timescale 1ns/1ps

`include "pkt_gen_defs.svh"

module tb_pkt_gen;
	import pkt_gen_pkg::*;

	localparam int ROWS    = 11;
	localparam int TIMEOUT = 4000;  // cycles allowed per wait loop
	localparam int QUIET   = 32;    // idle acked cycles that mean done

	typedef struct packed {
		len_mode_t mode;
		int        start_len;
		int        end_len;
		int        pkt_num;
		logic      end_sel;
		logic      ipg_sel;
		int        ack_low;    // percent of cycles with ack low
		int        en_cycles;  // free running rows only
	} row_t;

	logic      clk;
	logic      reset;
	logic      gen_en_i;
	len_mode_t len_mode_i;
	pkt_len_t  start_len_i;
	pkt_len_t  end_len_i;
	pkt_cnt_t  pkt_num_i;
	logic      end_sel_i;
	logic      ipg_sel_i;
	mac_t      dest_addr_i;
	mac_t      src_addr_i;
	logic      tx_ack_i;
	beat_t     tx_data_o;
	logic      tx_sop_o;
	logic      tx_eop_o;
	logic      tx_valid_o;
	empty_t    tx_empty_o;

	row_t rows [ROWS];
	row_t cur;          // row being applied
	int   ack_low_pct;

	// reference model advanced by the monitor
	int   exp_len;      // length of the next packet
	int   exp_idx;      // running header index
	int   pkt_len;
	int   pkt_beats;
	int   beat_no;
	logic in_pkt;
	int   pkt_cnt;      // sop beats seen in this row
	int   quiet;

	// outputs seen one cycle earlier
	logic   prev_ack;
	logic   prev_valid;
	logic   prev_sop;
	logic   prev_eop;
	empty_t prev_empty;
	beat_t  prev_data;

	pkt_gen_top u_pkt_gen_top (
		.clk         (clk),
		.reset       (reset),
		.gen_en_i    (gen_en_i),
		.len_mode_i  (len_mode_i),
		.start_len_i (start_len_i),
		.end_len_i   (end_len_i),
		.pkt_num_i   (pkt_num_i),
		.end_sel_i   (end_sel_i),
		.ipg_sel_i   (ipg_sel_i),
		.dest_addr_i (dest_addr_i),
		.src_addr_i  (src_addr_i),
		.tx_ack_i    (tx_ack_i),
		.tx_data_o   (tx_data_o),
		.tx_sop_o    (tx_sop_o),
		.tx_eop_o    (tx_eop_o),
		.tx_valid_o  (tx_valid_o),
		.tx_empty_o  (tx_empty_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // 40 ns period
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("FAIL: see errors above");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "run stopped");
	endtask

	// lower n words all equal word 0
	function automatic logic words_same(input beat_t b, input int n);
		logic ok;
		ok = 1'b1;
		for (int w = 1; w < n; w++)
			if (b[w*64 +: 64] !== b[63:0])
				ok = 1'b0;
		return ok;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#2;
		tx_ack_i = ($urandom % 100) >= ack_low_pct;  // random back-pressure
	endtask

	// one transferred beat against the model
	task automatic take_beat();
		int  d_len;
		logic last;
		if (!in_pkt) begin
			check_eq("tx_sop_o", tx_sop_o, 1'b1);
			pkt_len   = exp_len;
			pkt_beats = (pkt_len - `PG_CRC_BYTES + 63) / 64;
			beat_no   = 0;
			in_pkt    = 1'b1;
			pkt_cnt++;
			check_eq("tx_data_o dest", tx_data_o[511:464], dest_addr_i);
			check_eq("tx_data_o src", tx_data_o[463:416], src_addr_i);
			check_eq("tx_data_o len", tx_data_o[415:400], pkt_len - `PG_HDR_BYTES);
			check_eq("tx_data_o idx", tx_data_o[399:384], exp_idx[15:0]);
			check_eq("tx_data_o filler", words_same(tx_data_o, 6), 1'b1);
			exp_idx++;
			if (cur.mode == LEN_INCR)
				exp_len = (exp_len == cur.end_len) ? cur.start_len : exp_len + 1;
		end else begin
			check_eq("tx_sop_o", tx_sop_o, 1'b0);
			check_eq("tx_data_o filler", words_same(tx_data_o, 8), 1'b1);
		end
		d_len = pkt_len - `PG_CRC_BYTES;
		last  = (beat_no == pkt_beats - 1);
		check_eq("tx_eop_o", tx_eop_o, last);
		check_eq("tx_empty_o", tx_empty_o, last ? 64 * pkt_beats - d_len : 0);
		if (last)
			in_pkt = 1'b0;
		beat_no++;
	endtask

	// --------------------------------------------------
	// monitor samples mid cycle where all is stable
	// --------------------------------------------------
	always @(negedge clk) begin
		if (reset) begin
			prev_ack = 1'b1;
		end else begin
			if (!prev_ack) begin  // nothing may move after an ack-low edge
				check_eq("tx_valid_o held", tx_valid_o, prev_valid);
				check_eq("tx_sop_o held", tx_sop_o, prev_sop);
				check_eq("tx_eop_o held", tx_eop_o, prev_eop);
				check_eq("tx_empty_o held", tx_empty_o, prev_empty);
				check_eq("tx_data_o held", tx_data_o === prev_data, 1'b1);
			end
			if (tx_ack_i && tx_valid_o)
				take_beat();
			if (tx_valid_o)
				quiet = 0;
			else if (tx_ack_i)
				quiet++;
			prev_ack   = tx_ack_i;
			prev_valid = tx_valid_o;
			prev_sop   = tx_sop_o;
			prev_eop   = tx_eop_o;
			prev_empty = tx_empty_o;
			prev_data  = tx_data_o;
		end
	end

	// --------------------------------------------------
	// stimulus table and row sequencing
	// --------------------------------------------------
	task automatic fill_table();
		// mode, start, end, count, end_sel, ipg_sel, ack low %, enable cycles
		rows[0]  = '{LEN_FIXED, 64,   64,   3,  1'b1, 1'b1, 0,  0};
		rows[1]  = '{LEN_FIXED, 68,   68,   4,  1'b1, 1'b0, 20, 0};
		rows[2]  = '{LEN_FIXED, 69,   69,   3,  1'b1, 1'b1, 30, 0};
		rows[3]  = '{LEN_FIXED, 132,  132,  2,  1'b1, 1'b0, 0,  0};
		rows[4]  = '{LEN_FIXED, 133,  133,  3,  1'b1, 1'b1, 25, 0};
		rows[5]  = '{LEN_FIXED, 1500, 1500, 2,  1'b1, 1'b0, 10, 0};
		rows[6]  = '{LEN_INCR,  64,   70,   10, 1'b1, 1'b1, 0,  0};
		rows[7]  = '{LEN_INCR,  126,  131,  8,  1'b1, 1'b0, 35, 0};
		rows[8]  = '{LEN_FIXED, 100,  100,  0,  1'b1, 1'b1, 0,  0};  // empty burst
		rows[9]  = '{LEN_FIXED, 200,  200,  0,  1'b0, 1'b0, 15, 60};
		rows[10] = '{LEN_INCR,  64,   67,   0,  1'b0, 1'b1, 0,  25};
	endtask

	task automatic wait_quiet(input int r);
		int n;
		n     = 0;
		quiet = 0;
		while (quiet < QUIET) begin
			next_cycle();
			n++;
			if (n > TIMEOUT)
				stop_run($sformatf("row %0d: output never went idle", r));
		end
	endtask

	task automatic run_row(input int r);
		int n;
		len_mode_i  = cur.mode;
		start_len_i = pkt_len_t'(cur.start_len);
		end_len_i   = pkt_len_t'(cur.end_len);
		pkt_num_i   = pkt_cnt_t'(cur.pkt_num);
		end_sel_i   = cur.end_sel;
		ipg_sel_i   = cur.ipg_sel;
		ack_low_pct = cur.ack_low;
		exp_len     = cur.start_len;
		pkt_cnt     = 0;
		next_cycle();
		gen_en_i = 1'b1;
		if (cur.end_sel) begin
			repeat (8) next_cycle();  // let the synchronizer see the edge
			n = 0;
			while (pkt_cnt < cur.pkt_num || in_pkt) begin
				next_cycle();
				n++;
				if (n > TIMEOUT)
					stop_run($sformatf("row %0d: burst did not complete", r));
			end
		end else begin
			repeat (cur.en_cycles) next_cycle();
		end
		gen_en_i = 1'b0;
		wait_quiet(r);
		if (in_pkt)
			stop_run($sformatf("row %0d: output stopped inside a packet", r));
		if (cur.end_sel)
			check_eq("sop count", pkt_cnt, cur.pkt_num);
		else if (pkt_cnt == 0)
			stop_run($sformatf("row %0d: free-running row sent no packet", r));
	endtask

	initial begin
		void'($urandom(32'h7ac3_486e));
		reset       = 1'b1;
		gen_en_i    = 1'b0;
		len_mode_i  = LEN_FIXED;
		start_len_i = pkt_len_t'(64);
		end_len_i   = pkt_len_t'(64);
		pkt_num_i   = '0;
		end_sel_i   = 1'b0;
		ipg_sel_i   = 1'b1;
		dest_addr_i = 48'h02_11_22_33_44_55;
		src_addr_i  = 48'h02_aa_bb_cc_dd_ee;
		tx_ack_i    = 1'b1;
		ack_low_pct = 0;
		exp_idx     = 0;
		in_pkt      = 1'b0;
		pkt_cnt     = 0;
		quiet       = 0;
		fill_table();
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;
		check_eq("tx_valid_o", tx_valid_o, 1'b0);  // quiet out of reset
		check_eq("tx_sop_o", tx_sop_o, 1'b0);
		check_eq("tx_eop_o", tx_eop_o, 1'b0);
		for (int r = 0; r < ROWS; r++) begin
			cur = rows[r];
			run_row(r);
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- pkt_gen_top.sv
// ethernet test packet generator, 512-bit tx
`timescale 1ns/1ps

module pkt_gen_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   gen_en_i,     // async, synchronized inside
	input  pkt_gen_pkg::len_mode_t len_mode_i,
	input  pkt_gen_pkg::pkt_len_t  start_len_i,  // also the fixed length
	input  pkt_gen_pkg::pkt_len_t  end_len_i,
	input  pkt_gen_pkg::pkt_cnt_t  pkt_num_i,
	input  logic                   end_sel_i,
	input  logic                   ipg_sel_i,
	input  pkt_gen_pkg::mac_t      dest_addr_i,
	input  pkt_gen_pkg::mac_t      src_addr_i,
	input  logic                   tx_ack_i,     // low freezes the generator
	output pkt_gen_pkg::beat_t     tx_data_o,
	output logic                   tx_sop_o,
	output logic                   tx_eop_o,
	output logic                   tx_valid_o,
	output pkt_gen_pkg::empty_t    tx_empty_o
);

	logic [63:0] filler;  // random word for the framer
	logic        gap_ok;  // random inter-packet gap gate

	pkt_req_if u_req ();  // scheduler to framer

	// --------------------------------------------------
	// random source
	// --------------------------------------------------
	pkt_lfsr u_lfsr (
		.clk      (clk),
		.reset    (reset),
		.ack_i    (tx_ack_i),
		.filler_o (filler),
		.gap_ok_o (gap_ok)
	);

	// --------------------------------------------------
	// packet sequencing
	// --------------------------------------------------
	pkt_sched u_sched (
		.clk         (clk),
		.reset       (reset),
		.gen_en_i    (gen_en_i),
		.len_mode_i  (len_mode_i),
		.start_len_i (start_len_i),
		.end_len_i   (end_len_i),
		.pkt_num_i   (pkt_num_i),
		.end_sel_i   (end_sel_i),
		.ipg_sel_i   (ipg_sel_i),
		.gap_ok_i    (gap_ok),
		.ack_i       (tx_ack_i),
		.req         (u_req)
	);

	// --------------------------------------------------
	// beat output
	// --------------------------------------------------
	pkt_framer u_framer (
		.clk         (clk),
		.reset       (reset),
		.ack_i       (tx_ack_i),
		.dest_addr_i (dest_addr_i),
		.src_addr_i  (src_addr_i),
		.filler_i    (filler),
		.req         (u_req),
		.data_o      (tx_data_o),
		.sop_o       (tx_sop_o),
		.eop_o       (tx_eop_o),
		.valid_o     (tx_valid_o),
		.empty_o     (tx_empty_o)
	);

endmodule

//--- pkt_framer.sv
// beat builder, header then filler
`timescale 1ns/1ps

`include "pkt_gen_defs.svh"

module pkt_framer (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  ack_i,
	input  pkt_gen_pkg::mac_t     dest_addr_i,
	input  pkt_gen_pkg::mac_t     src_addr_i,
	input  logic [`PG_WORD_W-1:0] filler_i,
	pkt_req_if.framer             req,
	output pkt_gen_pkg::beat_t    data_o,
	output logic                  sop_o,
	output logic                  eop_o,
	output logic                  valid_o,
	output pkt_gen_pkg::empty_t   empty_o
);
	import pkt_gen_pkg::*;

	frm_state_t state;       // kind of beat now on the output
	pkt_len_t   rem;         // data bytes still owed after current beat
	logic       in_frame;    // sop moved, eop not yet
	pkt_len_t   d_len;       // bytes actually sent, no crc
	pkt_len_t   pay_len;     // header length field
	logic       first_last;  // whole packet fits the sop beat
	logic       mid_last;    // next filler beat closes the packet
	logic       in_pkt;
	beat_t      hdr_beat;
	beat_t      fill_beat;

	// --------------------------------------------------
	// descriptor decode
	// --------------------------------------------------
	assign d_len      = req.len - pkt_len_t'(`PG_CRC_BYTES);
	assign pay_len    = req.len - pkt_len_t'(`PG_HDR_BYTES);
	assign first_last = (d_len <= pkt_len_t'(`PG_BEAT_BYTES));  // L <= 68
	assign mid_last   = (rem <= pkt_len_t'(`PG_BEAT_BYTES));
	assign in_pkt     = (state == FRM_SOP) || (state == FRM_DATA);

	// start a packet when idle or while the eop beat is accepted
	assign req.take = req.avail & ack_i &
		((state == FRM_IDLE) | (state == FRM_EOP));

	// dest, src, length, index, then six filler words
	assign hdr_beat = {dest_addr_i, src_addr_i,
		{(16-`PG_LEN_W){1'b0}}, pay_len, req.idx,
		{(`PG_WORDS-2){filler_i}}};
	assign fill_beat = {`PG_WORDS{filler_i}};

	// --------------------------------------------------
	// beat state machine
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= FRM_IDLE;
			rem     <= '0;
			sop_o   <= 1'b0;
			eop_o   <= 1'b0;
			valid_o <= 1'b0;
			empty_o <= '0;
		end else if (ack_i) begin  // ack low holds everything
			if (req.take) begin
				sop_o   <= 1'b1;
				valid_o <= 1'b1;
				eop_o   <= first_last;
				// short packet, empty from the byte count mod 64
				empty_o <= first_last ? empty_t'(6'd0 - d_len[5:0]) : '0;
				rem     <= first_last ? '0 :
					pkt_len_t'(d_len - `PG_BEAT_BYTES);
				state   <= first_last ? FRM_EOP : FRM_SOP;
			end else if (in_pkt) begin
				sop_o   <= 1'b0;
				valid_o <= 1'b1;
				eop_o   <= mid_last;
				empty_o <= mid_last ? empty_t'(6'd0 - rem[5:0]) : '0;
				rem     <= mid_last ? '0 :
					pkt_len_t'(rem - `PG_BEAT_BYTES);
				state   <= mid_last ? FRM_EOP : FRM_DATA;
			end else begin
				// nothing taken, bus goes quiet
				sop_o   <= 1'b0;
				eop_o   <= 1'b0;
				valid_o <= 1'b0;
				empty_o <= '0;
				state   <= FRM_IDLE;
			end
		end
	end

	// payload only, control above decides validity
	always_ff @(posedge clk) begin
		if (ack_i) begin
			if (req.take)
				data_o <= hdr_beat;
			else if (in_pkt)
				data_o <= fill_beat;
		end
	end

	// --------------------------------------------------
	// framing checks
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			in_frame <= 1'b0;
		end else if (valid_o && ack_i) begin
			if (eop_o)
				in_frame <= 1'b0;
			else if (sop_o)
				in_frame <= 1'b1;
		end
	end

	a_sop_valid: assert property (@(posedge clk) disable iff (reset)
		sop_o |-> valid_o);
	a_eop_valid: assert property (@(posedge clk) disable iff (reset)
		eop_o |-> valid_o);
	// no second sop before the open packet has ended
	a_one_sop: assert property (@(posedge clk) disable iff (reset)
		in_frame |-> !sop_o);

endmodule

//--- pkt_sched.sv
// run control and length sequencing
`timescale 1ns/1ps

`include "pkt_gen_defs.svh"

module pkt_sched (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   gen_en_i,    // async enable
	input  pkt_gen_pkg::len_mode_t len_mode_i,
	input  pkt_gen_pkg::pkt_len_t  start_len_i,
	input  pkt_gen_pkg::pkt_len_t  end_len_i,
	input  pkt_gen_pkg::pkt_cnt_t  pkt_num_i,   // burst size when end_sel_i
	input  logic                   end_sel_i,   // 0 free running, 1 counted
	input  logic                   ipg_sel_i,   // 1 ignores gap decision
	input  logic                   gap_ok_i,
	input  logic                   ack_i,
	pkt_req_if.sched               req
);
	import pkt_gen_pkg::*;

	logic     en_s1;    // sync stage 1
	logic     en_s2;    // sync stage 2, safe to use
	logic     en_d;     // for edge detect
	logic     en_rise;
	logic     run;      // generator allowed to start packets
	pkt_cnt_t remain;   // packets left in counted burst
	pkt_len_t cur_len;
	pkt_idx_t cur_idx;

	// --------------------------------------------------
	// enable synchronizer
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			en_s1 <= 1'b0;
			en_s2 <= 1'b0;
			en_d  <= 1'b0;
		end else if (ack_i) begin  // frozen under back-pressure
			en_s1 <= gen_en_i;
			en_s2 <= en_s1;
			en_d  <= en_s2;
		end
	end

	assign en_rise = en_s2 & ~en_d;

	// --------------------------------------------------
	// run flag and burst count
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			run    <= 1'b0;
			remain <= '0;
		end else if (ack_i) begin
			if (!end_sel_i) begin
				run <= en_s2;  // free running, track the level
			end else if (en_rise) begin
				run    <= (pkt_num_i != '0);  // empty burst sends nothing
				remain <= pkt_num_i;
			end else if (req.take) begin
				remain <= remain - 1'b1;
				// last descriptor of the burst just went out
				if (remain <= pkt_cnt_t'(1))
					run <= 1'b0;
			end
		end
	end

	// --------------------------------------------------
	// length and index
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			cur_len <= start_len_i;
		end else if (ack_i) begin
			if (en_rise || len_mode_i == LEN_FIXED) begin
				cur_len <= start_len_i;
			end else if (req.take) begin
				// incrementing, wrap once end_len has been used
				cur_len <= (cur_len >= end_len_i) ? start_len_i :
					pkt_len_t'(cur_len + 1'b1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			cur_idx <= '0;
		else if (ack_i && req.take)
			cur_idx <= cur_idx + 1'b1;  // wraps at 16 bits
	end

	assign req.avail = run & (ipg_sel_i | gap_ok_i);  // gap gate
	assign req.len   = cur_len;
	assign req.idx   = cur_idx;

	// a descriptor offered to the framer must be a legal frame size
	a_len_range: assert property (@(posedge clk) disable iff (reset)
		req.avail |-> (req.len >= `PG_MIN_LEN && req.len <= `PG_MAX_LEN));

endmodule

//--- pkt_lfsr.sv
// pseudo-random filler and gap source
`timescale 1ns/1ps

`include "pkt_gen_defs.svh"

module pkt_lfsr (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  ack_i,     // step only on acked cycles
	output logic [`PG_WORD_W-1:0] filler_o,  // replicated across beats
	output logic                  gap_ok_o   // mostly 1
);

	logic [31:0] cntr;    // free running, perturbs both lfsrs
	logic [31:0] prand0;
	logic [31:0] prand1;
	logic [15:0] mix;     // combined 16 bits per step

	// --------------------------------------------------
	// counter and two galois lfsrs
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			cntr   <= '0;
			prand0 <= '1;  // all ones, never locks up at zero
			prand1 <= '1;
		end else if (ack_i) begin
			cntr <= cntr + 1'b1;
			// feedback bit xored with counter msb
			prand0 <= {prand0[30:0], 1'b0} ^
				((prand0[31] ^ cntr[31]) ? `PG_LFSR_POLY0 : 32'h0);
			prand1 <= {prand1[30:0], 1'b0} ^
				((prand1[31] ^ cntr[30]) ? `PG_LFSR_POLY1 : 32'h0);
		end
	end

	// --------------------------------------------------
	// whitened output words
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			mix      <= '0;
			filler_o <= '0;
			gap_ok_o <= 1'b0;  // no packet right out of reset
		end else if (ack_i) begin
			mix <= cntr[23:8] ^ prand0[15:0] ^ prand1[15:0];
			// 16 fresh bits shifted in per step
			filler_o <= {filler_o[`PG_WORD_W-17:0], mix};
			// or of two random pairs, high about 3 cycles in 4
			gap_ok_o <= |(prand0[17:16] ^ prand1[17:16] ^ cntr[25:24]);
		end
	end

endmodule

//--- pkt_req_if.sv
// next packet descriptor channel
`timescale 1ns/1ps

interface pkt_req_if;
	import pkt_gen_pkg::*;

	// --------------------------------------------------
	// scheduler side
	// --------------------------------------------------
	logic     avail;  // a packet may start now
	pkt_len_t len;    // length of the next packet
	pkt_idx_t idx;    // index stamped into its header

	// --------------------------------------------------
	// framer side
	// --------------------------------------------------
	logic     take;   // one cycle, descriptor consumed

	modport sched (
		output avail,
		output len,
		output idx,
		input  take
	);

	modport framer (
		input  avail,
		input  len,
		input  idx,
		output take
	);

endinterface

//--- pkt_gen_pkg.sv
// packet generator types

`include "pkt_gen_defs.svh"

package pkt_gen_pkg;

	// --------------------------------------------------
	// data path words
	// --------------------------------------------------
	typedef logic [`PG_WORDS*`PG_WORD_W-1:0] beat_t;   // one full bus beat
	typedef logic [5:0]                      empty_t;  // unused bytes in eop beat

	// --------------------------------------------------
	// header fields and counters
	// --------------------------------------------------
	typedef logic [`PG_LEN_W-1:0] pkt_len_t;  // frame length incl. crc
	typedef logic [47:0]          mac_t;
	typedef logic [15:0]          pkt_idx_t;  // running packet number
	typedef logic [`PG_CNT_W-1:0] pkt_cnt_t;  // burst size

	// length sequencing
	typedef enum logic {
		LEN_FIXED = 1'b0,  // every packet start_len
		LEN_INCR  = 1'b1   // start..end, then wrap
	} len_mode_t;

	// beat currently on the output
	typedef enum logic [1:0] {
		FRM_IDLE = 2'd0,  // nothing valid
		FRM_SOP  = 2'd1,  // header beat, more follow
		FRM_DATA = 2'd2,  // middle filler beat
		FRM_EOP  = 2'd3   // last beat of packet
	} frm_state_t;

endpackage

//--- pkt_gen_defs.svh
// packet generator constants
`ifndef PKT_GEN_DEFS_SVH
`define PKT_GEN_DEFS_SVH

// --------------------------------------------------
// bus geometry
// --------------------------------------------------
`define PG_WORDS       8     // 64-bit words per beat
`define PG_WORD_W      64
`define PG_BEAT_BYTES  64    // bytes moved per beat

// --------------------------------------------------
// packet sizing
// --------------------------------------------------
`define PG_LEN_W       14    // packet length field
`define PG_CNT_W       32    // burst packet count
`define PG_MIN_LEN     64    // shortest legal frame, crc included
`define PG_MAX_LEN     9600  // jumbo limit
`define PG_CRC_BYTES   4     // counted in length but never sent
`define PG_HDR_BYTES   18    // dest + src + len/type + crc

// --------------------------------------------------
// random source feedback taps
// --------------------------------------------------
`define PG_LFSR_POLY0  32'h8000_0241
`define PG_LFSR_POLY1  32'h8dea_dfb3

`endif
